/* Makefile */
# Verilator build and run of the data cache testbench

TOP := tb_dcache

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and replay the access trace"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* list.f */
rtl/dcache_pkg.sv
rtl/dcache_sweep_cnt.sv
rtl/dcache_ways.sv
rtl/dcache_plru.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
test/dcache_asserts.sv
test/tb_dcache.sv

/* rtl/dcache_ctrl.sv */
/*
  Data cache controller
  Accepts one CPU access at a time, looks it up, writes back a dirty
  victim, refills the line and replays the lookup until it hits
*/
`timescale 1ns/10ps

module dcache_ctrl #(
  parameter int NUM_WAY = 4,
  parameter int NUM_SET = 8,
  localparam int IDX_W  = $clog2(NUM_SET),
  localparam int TAG_W  = dcache_pkg::XLEN - dcache_pkg::OFFSET_BITS - IDX_W
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  dcache_pkg::cpu_req_t cpu_req_i,
  output logic                 cpu_ready_o,
  output dcache_pkg::cpu_res_t cpu_res_o,
  output dcache_pkg::mem_req_t mem_req_o,
  input  dcache_pkg::mem_res_t mem_res_i,
  output logic                 sweep_en_o,
  input  logic [IDX_W-1:0]     sweep_idx_i,
  input  logic                 sweep_done_i,
  output logic [IDX_W-1:0]     arr_idx_o,
  output logic                 clear_o,
  output logic                 tag_we_o,
  output logic                 data_we_o,
  output logic [NUM_WAY-1:0]   way_sel_o,
  output logic                 dirty_o,
  output dcache_pkg::line_u    fill_line_o,
  output dcache_pkg::cpu_req_t store_o,
  input  logic                 hit_i,
  input  logic [NUM_WAY-1:0]   hit_way_i,
  input  dcache_pkg::line_u    hit_line_i,
  input  logic [TAG_W-1:0]     victim_tag_i,
  input  logic                 victim_dirty_i,
  input  dcache_pkg::line_u    victim_line_i,
  input  logic [NUM_WAY-1:0]   victim_way_i,
  output logic                 plru_touch_o,
  output logic [NUM_WAY-1:0]   plru_way_o
);

  localparam int OFS = dcache_pkg::OFFSET_BITS;

  typedef enum logic [2:0] {
    ST_SWEEP,
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITEBACK,
    ST_REFILL
  } state_e;

  state_e               state_q, state_d;
  dcache_pkg::cpu_req_t req_q;
  dcache_pkg::cpu_res_t res_q;
  dcache_pkg::mem_req_t mem_req_q;
  dcache_pkg::mem_req_t wb_req;
  dcache_pkg::mem_req_t fill_req;
  logic [NUM_WAY-1:0]   victim_q;
  logic [IDX_W-1:0]     req_idx;
  logic                 miss_q;
  logic                 accept;

  assign cpu_ready_o = (state_q == ST_IDLE);
  assign accept      = cpu_req_i.valid && cpu_ready_o;
  assign req_idx     = req_q.addr[OFS +: IDX_W];

  // ==============================
  // Memory requests
  // ==============================
  always_comb begin
    // Victim line goes back to where its tag and this set say
    wb_req.valid   = 1'b1;
    wb_req.we      = 1'b1;
    wb_req.addr    = {victim_tag_i, req_idx, {OFS{1'b0}}};
    wb_req.wdata   = victim_line_i;

    fill_req.valid = 1'b1;
    fill_req.we    = 1'b0;
    fill_req.addr  = {req_q.addr[dcache_pkg::XLEN-1:OFS], {OFS{1'b0}}};
    fill_req.wdata = '0;
  end

  // ==============================
  // Next state and array control
  // ==============================
  always_comb begin
    state_d      = state_q;
    sweep_en_o   = 1'b0;
    arr_idx_o    = req_idx;
    tag_we_o     = 1'b0;
    data_we_o    = 1'b0;
    way_sel_o    = hit_way_i;
    dirty_o      = 1'b0;
    plru_touch_o = 1'b0;
    case (state_q)
      ST_SWEEP: begin
        sweep_en_o = !sweep_done_i;
        arr_idx_o  = sweep_idx_i;
        if (sweep_done_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_IDLE: begin
        // Present the incoming index so the arrays are read on acceptance
        arr_idx_o = cpu_req_i.addr[OFS +: IDX_W];
        if (accept) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (hit_i) begin
          data_we_o    = req_q.we;
          dirty_o      = 1'b1;
          plru_touch_o = 1'b1;
          state_d      = ST_IDLE;
        end else if (victim_dirty_i) begin
          state_d = ST_WRITEBACK;
        end else begin
          state_d = ST_REFILL;
        end
      end
      ST_WRITEBACK: begin
        if (mem_res_i.valid) begin
          state_d = ST_REFILL;
        end
      end
      ST_REFILL: begin
        if (mem_res_i.valid) begin
          tag_we_o  = 1'b1;
          data_we_o = 1'b1;
          way_sel_o = victim_q;
          state_d   = ST_LOOKUP;
        end
      end
      default: state_d = ST_SWEEP;
    endcase
  end

  assign clear_o     = sweep_en_o;
  assign plru_way_o  = hit_way_i;
  assign fill_line_o = mem_res_i.rdata;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= ST_SWEEP;
      miss_q    <= 1'b0;
      res_q     <= '0;
      mem_req_q <= '0;
    end else begin
      state_q     <= state_d;
      res_q.valid <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            miss_q <= 1'b0;
          end
        end
        ST_LOOKUP: begin
          if (hit_i) begin
            res_q.valid <= 1'b1;
            res_q.hit   <= !miss_q;
            res_q.rdata <= hit_line_i.words[req_q.addr[OFS-1:2]];
          end else begin
            miss_q    <= 1'b1;
            mem_req_q <= victim_dirty_i ? wb_req : fill_req;
          end
        end
        ST_WRITEBACK: begin
          if (mem_res_i.valid) begin
            mem_req_q <= fill_req;
          end
        end
        ST_REFILL: begin
          if (mem_res_i.valid) begin
            mem_req_q.valid <= 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

  // Request and chosen victim
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= cpu_req_i;
    end
    if (state_q == ST_LOOKUP && !hit_i) begin
      victim_q <= victim_way_i;
    end
  end

  assign store_o   = req_q;
  assign cpu_res_o = res_q;
  assign mem_req_o = mem_req_q;

endmodule

/* rtl/dcache_pkg.sv */
/*
  Data cache shared definitions
  Address and line geometry, access sizes, the CPU and memory port
  structs, and the line view shared by the way arrays and the controller
*/
package dcache_pkg;

  // ==============================
  // Geometry
  // ==============================
  localparam int XLEN           = 32;
  localparam int LINE_BITS      = 128;
  localparam int WORDS_PER_LINE = 4;
  localparam int OFFSET_BITS    = 4;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } rw_size_e;

  // ==============================
  // Port structs
  // ==============================
  typedef struct packed {
    logic            valid;
    logic            we;
    rw_size_e        size;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic            valid;
    logic            hit;
    logic [XLEN-1:0] rdata;
  } cpu_res_t;

  // Line request, address is always line aligned
  typedef struct packed {
    logic                 valid;
    logic                 we;
    logic [XLEN-1:0]      addr;
    logic [LINE_BITS-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                 valid;
    logic [LINE_BITS-1:0] rdata;
  } mem_res_t;

  // One cache line seen as words or as bytes
  typedef union packed {
    logic [WORDS_PER_LINE-1:0][XLEN-1:0] words;
    logic [LINE_BITS/8-1:0][7:0]         bytes;
  } line_u;

endpackage

/* rtl/dcache_plru.sv */
/*
  Tree pseudo-LRU
  Keeps NUM_WAY-1 node bits per set, steers every node on a touched
  path away from that way and follows the nodes to the victim leaf
*/
`timescale 1ns/10ps

module dcache_plru #(
  parameter int NUM_WAY = 4,
  parameter int NUM_SET = 8,
  localparam int IDX_W  = $clog2(NUM_SET)
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [IDX_W-1:0]   idx_i,
  input  logic               clear_i,
  input  logic               touch_i,
  input  logic [NUM_WAY-1:0] way_i,
  output logic [NUM_WAY-1:0] victim_o
);

  localparam int LVL = $clog2(NUM_WAY);

  // Node n has children 2n+1 (bit 0) and 2n+2 (bit 1)
  logic [NUM_WAY-2:0] node_q [NUM_SET];
  logic [IDX_W-1:0]   idx_q;
  logic [NUM_WAY-2:0] node_upd;
  logic [LVL-1:0]     touch_bin;
  logic [LVL-1:0]     victim_bin;

  always_comb begin
    int n;
    logic dir;
    touch_bin = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (way_i[w]) begin
        touch_bin = LVL'(w);
      end
    end
    node_upd = node_q[idx_i];
    n = 0;
    for (int l = 0; l < LVL; l++) begin
      dir         = touch_bin[LVL-1-l];
      node_upd[n] = ~dir;
      n           = 2 * n + 1 + int'(dir);
    end
  end

  // Victim follows the stored bits from the root
  always_comb begin
    int n;
    logic dir;
    n = 0;
    for (int l = 0; l < LVL; l++) begin
      dir                  = node_q[idx_q][n];
      victim_bin[LVL-1-l] = dir;
      n                    = 2 * n + 1 + int'(dir);
    end
    victim_o             = '0;
    victim_o[victim_bin] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      idx_q <= '0;
      for (int s = 0; s < NUM_SET; s++) begin
        node_q[s] <= '0;
      end
    end else begin
      idx_q <= idx_i;
      if (clear_i) begin
        node_q[idx_i] <= '0;
      end else if (touch_i) begin
        node_q[idx_i] <= node_upd;
      end
    end
  end

endmodule

/* rtl/dcache_sweep_cnt.sv */
/*
  Set sweep counter
  Steps through every set once after reset, one per enabled cycle,
  and then flags that the sweep is complete
*/
`timescale 1ns/10ps

module dcache_sweep_cnt #(
  parameter int NUM_SET = 8,
  localparam int IDX_W  = $clog2(NUM_SET)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             en_i,
  output logic [IDX_W-1:0] idx_o,
  output logic             done_o
);

  logic [IDX_W-1:0] idx_q;
  logic             done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      idx_q  <= '0;
      done_q <= 1'b0;
    end else if (en_i && !done_q) begin
      if (idx_q == IDX_W'(NUM_SET - 1)) begin
        // Last set cleared this cycle
        idx_q  <= '0;
        done_q <= 1'b1;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  assign idx_o  = idx_q;
  assign done_o = done_q;

endmodule

/* rtl/dcache_top.sv */
/*
  Write-back set-associative data cache
  Joins the controller FSM, the post-reset sweep counter, the way
  arrays and the pseudo-LRU tree between the CPU and memory ports
*/
`timescale 1ns/10ps

module dcache_top #(
  parameter int NUM_WAY = 4,
  parameter int NUM_SET = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  dcache_pkg::cpu_req_t cpu_req_i,
  output logic                 cpu_ready_o,
  output dcache_pkg::cpu_res_t cpu_res_o,
  output dcache_pkg::mem_req_t mem_req_o,
  input  dcache_pkg::mem_res_t mem_res_i
);

  localparam int IDX_W = $clog2(NUM_SET);
  localparam int TAG_W = dcache_pkg::XLEN - dcache_pkg::OFFSET_BITS - IDX_W;

  // Sweep
  logic                 sweep_en;
  logic [IDX_W-1:0]     sweep_idx;
  logic                 sweep_done;

  // Array control from the FSM
  logic [IDX_W-1:0]     arr_idx;
  logic                 clear;
  logic                 tag_we;
  logic                 data_we;
  logic [NUM_WAY-1:0]   way_sel;
  logic                 dirty;
  dcache_pkg::line_u    fill_line;
  dcache_pkg::cpu_req_t store;

  // Array results
  logic                 hit;
  logic [NUM_WAY-1:0]   hit_way;
  dcache_pkg::line_u    hit_line;
  logic [TAG_W-1:0]     victim_tag;
  logic                 victim_dirty;
  dcache_pkg::line_u    victim_line;

  // Replacement
  logic                 plru_touch;
  logic [NUM_WAY-1:0]   plru_way;
  logic [NUM_WAY-1:0]   victim_way;

  dcache_ctrl #(
    .NUM_WAY(NUM_WAY),
    .NUM_SET(NUM_SET)
  ) u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cpu_req_i     (cpu_req_i),
    .cpu_ready_o   (cpu_ready_o),
    .cpu_res_o     (cpu_res_o),
    .mem_req_o     (mem_req_o),
    .mem_res_i     (mem_res_i),
    .sweep_en_o    (sweep_en),
    .sweep_idx_i   (sweep_idx),
    .sweep_done_i  (sweep_done),
    .arr_idx_o     (arr_idx),
    .clear_o       (clear),
    .tag_we_o      (tag_we),
    .data_we_o     (data_we),
    .way_sel_o     (way_sel),
    .dirty_o       (dirty),
    .fill_line_o   (fill_line),
    .store_o       (store),
    .hit_i         (hit),
    .hit_way_i     (hit_way),
    .hit_line_i    (hit_line),
    .victim_tag_i  (victim_tag),
    .victim_dirty_i(victim_dirty),
    .victim_line_i (victim_line),
    .victim_way_i  (victim_way),
    .plru_touch_o  (plru_touch),
    .plru_way_o    (plru_way)
  );

  dcache_sweep_cnt #(
    .NUM_SET(NUM_SET)
  ) u_sweep (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .en_i  (sweep_en),
    .idx_o (sweep_idx),
    .done_o(sweep_done)
  );

  dcache_ways #(
    .NUM_WAY(NUM_WAY),
    .NUM_SET(NUM_SET)
  ) u_ways (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .idx_i         (arr_idx),
    .clear_i       (clear),
    .tag_we_i      (tag_we),
    .data_we_i     (data_we),
    .way_sel_i     (way_sel),
    .dirty_i       (dirty),
    .fill_line_i   (fill_line),
    .store_i       (store),
    .hit_o         (hit),
    .hit_way_o     (hit_way),
    .hit_line_o    (hit_line),
    .victim_sel_i  (victim_way),
    .victim_tag_o  (victim_tag),
    .victim_dirty_o(victim_dirty),
    .victim_line_o (victim_line)
  );

  dcache_plru #(
    .NUM_WAY(NUM_WAY),
    .NUM_SET(NUM_SET)
  ) u_plru (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .idx_i   (arr_idx),
    .clear_i (clear),
    .touch_i (plru_touch),
    .way_i   (plru_way),
    .victim_o(victim_way)
  );

endmodule

/* rtl/dcache_ways.sv */
/*
  Way arrays
  Tag plus valid and line storage per way with a synchronous read,
  dirty bits per way and set, tag compare, victim select and the
  byte merge of a store into the hit line
*/
`timescale 1ns/10ps

module dcache_ways #(
  parameter int NUM_WAY = 4,
  parameter int NUM_SET = 8,
  localparam int IDX_W  = $clog2(NUM_SET),
  localparam int TAG_W  = dcache_pkg::XLEN - dcache_pkg::OFFSET_BITS - IDX_W
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [IDX_W-1:0]     idx_i,
  input  logic                 clear_i,
  input  logic                 tag_we_i,
  input  logic                 data_we_i,
  input  logic [NUM_WAY-1:0]   way_sel_i,
  input  logic                 dirty_i,
  input  dcache_pkg::line_u    fill_line_i,
  input  dcache_pkg::cpu_req_t store_i,
  output logic                 hit_o,
  output logic [NUM_WAY-1:0]   hit_way_o,
  output dcache_pkg::line_u    hit_line_o,
  input  logic [NUM_WAY-1:0]   victim_sel_i,
  output logic [TAG_W-1:0]     victim_tag_o,
  output logic                 victim_dirty_o,
  output dcache_pkg::line_u    victim_line_o
);

  localparam int OFS = dcache_pkg::OFFSET_BITS;

  // Tag entry is {valid, tag}
  logic [TAG_W:0]    tag_mem   [NUM_WAY][NUM_SET];
  logic [TAG_W:0]    tag_rd_q  [NUM_WAY];
  dcache_pkg::line_u data_mem  [NUM_WAY][NUM_SET];
  dcache_pkg::line_u data_rd_q [NUM_WAY];
  logic [NUM_WAY-1:0] dirty_q  [NUM_SET];
  logic [IDX_W-1:0]  idx_q;

  logic [NUM_WAY-1:0] tag_wr;
  logic [NUM_WAY-1:0] data_wr;
  logic [TAG_W:0]     tag_wdata;
  dcache_pkg::line_u  data_wdata;
  dcache_pkg::line_u  merge_line;
  logic [NUM_WAY-1:0] dirty_rd;
  logic [TAG_W-1:0]   req_tag;

  assign req_tag   = store_i.addr[dcache_pkg::XLEN-1 -: TAG_W];
  assign tag_wdata = clear_i ? '0 : {1'b1, req_tag};
  assign data_wdata = tag_we_i ? fill_line_i : merge_line;
  assign dirty_rd  = dirty_q[idx_q];

  always_comb begin
    for (int w = 0; w < NUM_WAY; w++) begin
      tag_wr[w]  = clear_i || (tag_we_i && way_sel_i[w]);
      data_wr[w] = !clear_i && data_we_i && way_sel_i[w];
    end
  end

  // ==============================
  // Storage, write-first read
  // ==============================
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAY; w++) begin
      if (tag_wr[w]) begin
        tag_mem[w][idx_i] <= tag_wdata;
        tag_rd_q[w]       <= tag_wdata;
      end else begin
        tag_rd_q[w] <= tag_mem[w][idx_i];
      end
      if (data_wr[w]) begin
        data_mem[w][idx_i] <= data_wdata;
        data_rd_q[w]       <= data_wdata;
      end else begin
        data_rd_q[w] <= data_mem[w][idx_i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      idx_q <= '0;
      for (int s = 0; s < NUM_SET; s++) begin
        dirty_q[s] <= '0;
      end
    end else begin
      idx_q <= idx_i;
      if (clear_i) begin
        dirty_q[idx_i] <= '0;
      end else begin
        for (int w = 0; w < NUM_WAY; w++) begin
          if (data_wr[w]) begin
            dirty_q[idx_i][w] <= dirty_i;
          end
        end
      end
    end
  end

  // ==============================
  // Compare and select
  // ==============================
  always_comb begin
    hit_line_o     = '0;
    victim_tag_o   = '0;
    victim_dirty_o = 1'b0;
    victim_line_o  = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      hit_way_o[w] = tag_rd_q[w][TAG_W] && (tag_rd_q[w][TAG_W-1:0] == req_tag);
      if (hit_way_o[w]) begin
        hit_line_o = hit_line_o | data_rd_q[w];
      end
      if (victim_sel_i[w]) begin
        victim_tag_o   = tag_rd_q[w][TAG_W-1:0];
        victim_dirty_o = dirty_rd[w] && tag_rd_q[w][TAG_W];
        victim_line_o  = data_rd_q[w];
      end
    end
  end

  assign hit_o = |hit_way_o;

  // Store data replicated across the word so each lane finds its byte
  always_comb begin
    logic [dcache_pkg::XLEN-1:0] rep;
    logic [OFS-1:0]              pos;
    logic                        lane_ok;
    case (store_i.size)
      dcache_pkg::SIZE_BYTE: rep = {4{store_i.wdata[7:0]}};
      dcache_pkg::SIZE_HALF: rep = {2{store_i.wdata[15:0]}};
      default:               rep = store_i.wdata;
    endcase
    merge_line = hit_line_o;
    for (int b = 0; b < dcache_pkg::LINE_BITS / 8; b++) begin
      pos = OFS'(b);
      case (store_i.size)
        dcache_pkg::SIZE_BYTE: lane_ok = (pos[1:0] == store_i.addr[1:0]);
        dcache_pkg::SIZE_HALF: lane_ok = (pos[1] == store_i.addr[1]);
        default:               lane_ok = 1'b1;
      endcase
      if (store_i.we && lane_ok && (pos[OFS-1:2] == store_i.addr[OFS-1:2])) begin
        merge_line.bytes[b] = rep[8*pos[1:0] +: 8];
      end
    end
  end

endmodule

/* test/dcache_asserts.sv */
/*
  Cache protocol assertions
  Watch the memory request hold, the response pulse width and
  the single CPU access in flight at the cache top level
*/
`timescale 1ns/10ps

module dcache_asserts (
  input logic                 clk_i,
  input logic                 rst_ni,
  input dcache_pkg::cpu_req_t cpu_req_i,
  input logic                 cpu_ready_i,
  input dcache_pkg::cpu_res_t cpu_res_i,
  input dcache_pkg::mem_req_t mem_req_i,
  input dcache_pkg::mem_res_t mem_res_i
);

  int   fail_hold  = 0;
  int   fail_pulse = 0;
  int   fail_busy  = 0;
  logic in_flight_q;

  // Accepted and not yet answered
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      in_flight_q <= 1'b0;
    end else if (cpu_req_i.valid && cpu_ready_i) begin
      in_flight_q <= 1'b1;
    end else if (cpu_res_i.valid) begin
      in_flight_q <= 1'b0;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i.valid && !mem_res_i.valid |=> $stable(mem_req_i))
  else begin
    $error("Memory request changed before its response");
    fail_hold++;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cpu_res_i.valid |=> !cpu_res_i.valid)
  else begin
    $error("CPU response valid held longer than one cycle");
    fail_pulse++;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_flight_q && !cpu_res_i.valid |-> !cpu_ready_i)
  else begin
    $error("Cache ready while an access is in flight");
    fail_busy++;
  end

endmodule

bind dcache_top dcache_asserts u_asserts (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .cpu_req_i  (cpu_req_i),
  .cpu_ready_i(cpu_ready_o),
  .cpu_res_i  (cpu_res_o),
  .mem_req_i  (mem_req_o),
  .mem_res_i  (mem_res_i)
);

/* test/dcache_trace.txt */
# Columns: op (R load, W store), address, size (B H W), write data,
# expected read data (checked on loads only), expected hit flag
# A line starting with T names the test of the lines below it
T sweep_first_read
R 00000104 W 00000000 A5A50104 0
R 0000010C W 00000000 A5A5010C 1
T store_merge
W 00000100 B 000000EE 00000000 1
W 00000101 B 00000077 00000000 1
W 00000106 H 0000BEEF 00000000 1
W 00000108 W 12345678 00000000 1
R 00000100 W 00000000 A5A577EE 1
R 00000104 W 00000000 BEEF0104 1
R 00000108 W 00000000 12345678 1
R 0000010C W 00000000 A5A5010C 1
W 00000212 H 0000CAFE 00000000 0
W 00000213 B 00000011 00000000 1
R 00000210 W 00000000 11FE0210 1
T dirty_writeback
W 00000024 W DEADBEEF 00000000 0
R 000000A0 W 00000000 A5A500A0 0
R 00000120 W 00000000 A5A50120 0
R 000001A0 W 00000000 A5A501A0 0
R 00000220 W 00000000 A5A50220 0
R 00000024 W 00000000 DEADBEEF 0
R 00000020 W 00000000 A5A50020 1
T plru_order
R 00000030 W 00000000 A5A50030 0
R 000000B0 W 00000000 A5A500B0 0
R 00000130 W 00000000 A5A50130 0
R 000001B0 W 00000000 A5A501B0 0
R 00000030 W 00000000 A5A50030 1
R 00000230 W 00000000 A5A50230 0
R 00000030 W 00000000 A5A50030 1
R 000000B0 W 00000000 A5A500B0 0
R 00000134 W 00000000 A5A50134 1
T busy_miss
W 00000044 W 0BADF00D 00000000 0
W 000000C8 W 55AA55AA 00000000 0
R 00000044 W 00000000 0BADF00D 1
R 000000C8 W 00000000 55AA55AA 1
R 00000040 W 00000000 A5A50040 1

/* test/tb_dcache.sv */
/*
  Data cache testbench
  Replays the access trace against the cache, models a line memory
  with random response latency and checks read data, hit flags,
  hit timing and the one-access-in-flight handshake
*/
`timescale 1ns/10ps

module tb_dcache;

  localparam int NUM_SET   = 8;
  localparam int MEM_WORDS = 1024;
  localparam int MAX_LINES = 256;
  localparam int MAX_WAIT  = 4;

  logic                 clk;
  logic                 rst_n;
  dcache_pkg::cpu_req_t cpu_req;
  logic                 cpu_ready;
  dcache_pkg::cpu_res_t cpu_res;
  dcache_pkg::mem_req_t mem_req;
  dcache_pkg::mem_res_t mem_res;

  // Trace entries
  logic                 tr_we    [MAX_LINES];
  dcache_pkg::rw_size_e tr_size  [MAX_LINES];
  logic [31:0]          tr_addr  [MAX_LINES];
  logic [31:0]          tr_wdata [MAX_LINES];
  logic [31:0]          tr_rdata [MAX_LINES];
  logic                 tr_hit   [MAX_LINES];
  string                tr_name  [MAX_LINES];
  int                   n_lines;
  string                cur_test;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] lcg_state;
  int          mem_wait;
  int          errors;
  int          res_count;
  int          cycle;
  int          cycle_limit;

  dcache_top dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .cpu_req_i  (cpu_req),
    .cpu_ready_o(cpu_ready),
    .cpu_res_o  (cpu_res),
    .mem_req_o  (mem_req),
    .mem_res_i  (mem_res)
  );

  always #10 clk = ~clk;

  // ==============================
  // Memory model
  // ==============================
  function automatic int next_latency();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    // Busy test always sees the slowest memory
    if (cur_test == "busy_miss") begin
      return MAX_WAIT;
    end
    return 1 + int'(lcg_state[17:16]);
  endfunction

  task automatic serve_request();
    int base;
    base = int'(mem_req.addr[11:4]) * dcache_pkg::WORDS_PER_LINE;
    assert (mem_req.addr[3:0] == 4'h0) else begin
      $display("[ERROR] mem_align: expected %08h actual %08h",
               {mem_req.addr[31:4], 4'h0}, mem_req.addr);
      errors++;
    end
    assert (mem_req.addr[31:12] == '0) else begin
      $display("Memory request at %08h is outside the modeled memory", mem_req.addr);
      errors++;
    end
    for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
      if (mem_req.we) begin
        mem[base + w] = mem_req.wdata[32*w +: 32];
      end else begin
        mem_res.rdata[32*w +: 32] = mem[base + w];
      end
    end
    mem_res.valid = 1'b1;
  endtask

  // A fresh request is one seen while no countdown runs
  always @(posedge clk) begin
    #2;
    mem_res.valid = 1'b0;
    if (mem_req.valid) begin
      if (mem_wait == 0) begin
        mem_wait = next_latency();
      end
      mem_wait--;
      if (mem_wait == 0) begin
        serve_request();
      end
    end
  end

  always @(posedge clk) begin
    #2;
    if (cpu_res.valid === 1'b1) begin
      res_count++;
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle_limit > 0 && cycle >= cycle_limit) begin
      $display("Timeout, no finish after %0d cycles", cycle);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ==============================
  // Trace reading and replay
  // ==============================
  task automatic load_trace();
    int          fd;
    int          rc;
    int          hit;
    string       line;
    string       op;
    string       sz;
    string       name;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    name    = "unnamed";
    n_lines = 0;
    fd = $fopen("test/dcache_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file test/dcache_trace.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && n_lines < MAX_LINES) begin
      rc = $fgets(line, fd);
      if (rc == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      if (line[0] == "T") begin
        rc = $sscanf(line, "T %s", name);
        continue;
      end
      rc = $sscanf(line, "%s %h %s %h %h %d", op, addr, sz, wdata, rdata, hit);
      if (rc != 6) begin
        $display("Trace line could not be parsed: %s", line);
        errors++;
        continue;
      end
      tr_we[n_lines]    = (op == "W");
      tr_size[n_lines]  = (sz == "B") ? dcache_pkg::SIZE_BYTE :
                          (sz == "H") ? dcache_pkg::SIZE_HALF : dcache_pkg::SIZE_WORD;
      tr_addr[n_lines]  = addr;
      tr_wdata[n_lines] = wdata;
      tr_rdata[n_lines] = rdata;
      tr_hit[n_lines]   = (hit != 0);
      tr_name[n_lines]  = name;
      n_lines++;
    end
    $fclose(fd);
  endtask

  task automatic check_response(input int i, input int lat);
    // Stores return the old word, so only loads carry read data
    if (!tr_we[i]) begin
      assert (cpu_res.rdata == tr_rdata[i]) else begin
        $display("[ERROR] %s access %0d rdata: expected %08h actual %08h",
                 tr_name[i], i, tr_rdata[i], cpu_res.rdata);
        errors++;
      end
    end
    assert (cpu_res.hit == tr_hit[i]) else begin
      $display("[ERROR] %s access %0d hit: expected %0d actual %0d",
               tr_name[i], i, tr_hit[i], cpu_res.hit);
      errors++;
    end
    if (tr_hit[i]) begin
      assert (lat == 2) else begin
        $display("[ERROR] %s access %0d latency: expected 2 actual %0d",
                 tr_name[i], i, lat);
        errors++;
      end
    end else begin
      assert (lat > 2) else begin
        $display("%s access %0d missed but answered in %0d cycles", tr_name[i], i, lat);
        errors++;
      end
    end
  endtask

  task automatic run_access(input int i);
    int lat;
    cur_test      = tr_name[i];
    cpu_req.valid = 1'b1;
    cpu_req.we    = tr_we[i];
    cpu_req.size  = tr_size[i];
    cpu_req.addr  = tr_addr[i];
    cpu_req.wdata = tr_wdata[i];
    while (!cpu_ready) begin
      @(posedge clk);
      #2;
    end
    // Taken on this edge
    @(posedge clk);
    #2;
    cpu_req.valid = 1'b0;
    lat = 1;
    while (!cpu_res.valid) begin
      assert (!cpu_ready) else begin
        $display("%s access %0d: cache ready while busy", tr_name[i], i);
        errors++;
      end
      @(posedge clk);
      #2;
      lat++;
    end
    check_response(i, lat);
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    cpu_req     = '0;
    mem_res     = '0;
    mem_wait    = 0;
    errors      = 0;
    res_count   = 0;
    cycle       = 0;
    cycle_limit = 0;
    cur_test    = "";
    lcg_state   = 32'd10354;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'(i * 4) ^ 32'hA5A5_0000;
    end
    load_trace();
    cycle_limit = 16 + NUM_SET + 40 * n_lines;

    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (NUM_SET) begin
      @(posedge clk);
      #2;
      assert (!cpu_ready) else begin
        $display("Cache took requests during the post-reset sweep");
        errors++;
      end
    end

    for (int i = 0; i < n_lines; i++) begin
      run_access(i);
    end
    @(posedge clk);
    #2;
    assert (res_count == n_lines) else begin
      $display("[ERROR] response_count: expected %0d actual %0d", n_lines, res_count);
      errors++;
    end
    errors += dut.u_asserts.fail_hold + dut.u_asserts.fail_pulse + dut.u_asserts.fail_busy;

    $display("Errors: %0d, responses %0d of %0d", errors, res_count, n_lines);
    if (errors == 0 && n_lines > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
